//--- design/sdInit_macros.svh
// Frame sizes, bus timing constants and fixed command arguments
// for the SD-card initialization host
`ifndef SD_INIT_MACROS_SVH
`define SD_INIT_MACROS_SVH

// Command frame and short response length in bits
`define SD_FRAME_BITS 48
// R2 response length in bits
`define SD_LONG_BITS 136
// N_CC and N_RC, in card-clock cycles
`define SD_GAP_CYCLES 8
// clk cycles per half card clock (at least 2)
`define SD_CLK_HALF 4

// CMD8 check pattern and argument (2.7-3.6 V)
`define SD_CHECK_PATTERN 8'hAA
`define SD_IF_ARG 32'h000001AA
// ACMD41 with HCS, XPC, S18R and the 2.7-2.8 V window
`define SD_OPCOND_ARG 32'h51008000
// ACMD6 with a 4-bit bus
`define SD_BUSWIDTH_ARG 32'h00000002

`endif

//--- design/sdInitPkg.sv
// Shared types for the SD-card initialization host
// Sequencer states, command indices and response kinds
`default_nettype none

package sdInitPkg;

    // Sequencer states, one per command step plus the shared bus phases
    typedef enum logic [4:0] {
        idle, go,
        ifCond, ifCheck,
        appCmd, opCond, opCheck,
        allCid,
        relAddr, rcaLatch,
        select,
        busAppCmd, busWidth,
        issue, await, gap,
        finished, failed
    } seqState_t;

    // Command indices sent on the CMD line
    // CMD55 is the prefix of every application command
    typedef enum logic [5:0] {
        goIdle      = 6'd0,
        allSendCid  = 6'd2,
        sendRelAddr = 6'd3,
        setBusWidth = 6'd6,
        selectCard  = 6'd7,
        sendIfCond  = 6'd8,
        sendOpCond  = 6'd41,
        appCommand  = 6'd55
    } sdCmd_t;

    // Reply kinds for R1/R6/R7, R3 without CRC and the long R2
    typedef enum logic [1:0] {none, short48, shortNoCrc, long136} respKind_t;

endpackage

`default_nettype wire

//--- design/sdCrc7.sv
// Serial CRC7 generator, polynomial x^7 + x^3 + 1
`timescale 1ns/100ps
`default_nettype none

module sdCrc7 (
    input  wire        clk,
    input  wire        arstN,
    input  wire        clear,
    input  wire        shiftEn,
    input  wire        dataBit,
    output logic [6:0] crc
);

    // Feedback is the incoming bit against the top register bit
    logic feedback;
    assign feedback = dataBit ^ crc[6];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shiftEn) begin
            // Taps at x^3 and x^0
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

`default_nettype wire

//--- design/sdCmdSender.sv
// Command frame serializer for the SD CMD line
// Shifts one 48-bit frame out on card-clock falling edges with its CRC7
`timescale 1ns/100ps
`default_nettype none
`include "sdInit_macros.svh"

module sdCmdSender (
    input  wire                clk,
    input  wire                arstN,
    input  wire                fallTick,
    input  wire                sendStart,
    input  sdInitPkg::sdCmd_t  cmdIndex,
    input  wire [31:0]         cmdArg,
    output logic               cmdOut,
    output logic               cmdOutEn,
    output logic               sendDone
);

    logic [47:0] frame;
    logic [5:0]  bitCnt;
    logic        busy;
    logic [6:0]  crc;
    logic        crcEn;

    // CRC covers start, transmission, index and argument
    assign crcEn = fallTick && busy && (bitCnt < 6'(`SD_FRAME_BITS - 8));

    sdCrc7 crcGen (
        .clk     (clk),
        .arstN   (arstN),
        .clear   (sendStart),
        .shiftEn (crcEn),
        .dataBit (frame[47]),
        .crc     (crc)
    );

    // Outgoing frame, MSB leaves first
    always_ff @(posedge clk) begin
        if (sendStart) begin
            // Start 0, transmission 1, CRC slot left empty, end 1
            frame <= {2'b01, cmdIndex, cmdArg, 7'd0, 1'b1};
        end else if (fallTick && busy) begin
            if (bitCnt == 6'(`SD_FRAME_BITS - 8)) begin
                // Drop the CRC in behind the bit leaving now
                frame <= {crc[5:0], frame[40:0], 1'b0};
            end else begin
                frame <= {frame[46:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy     <= 1'b0;
            bitCnt   <= '0;
            cmdOut   <= 1'b1;
            cmdOutEn <= 1'b0;
            sendDone <= 1'b0;
        end else begin
            sendDone <= 1'b0;
            if (sendStart) begin
                busy   <= 1'b1;
                bitCnt <= '0;
            end else if (fallTick && busy) begin
                if (bitCnt == 6'(`SD_FRAME_BITS)) begin
                    // End bit has had its full card-clock cycle
                    busy     <= 1'b0;
                    cmdOutEn <= 1'b0;
                    cmdOut   <= 1'b1;
                    sendDone <= 1'b1;
                end else begin
                    cmdOutEn <= 1'b1;
                    cmdOut   <= (bitCnt == 6'(`SD_FRAME_BITS - 8)) ? crc[6] : frame[47];
                    bitCnt   <= bitCnt + 1'b1;
                end
            end
        end
    end

    // The FSM keeps one command in flight
    assert property (@(posedge clk) disable iff (!arstN) sendStart |-> !cmdOutEn && !busy);

endmodule

`default_nettype wire

//--- design/sdRespReceiver.sv
// Response receiver for the SD CMD line
// Waits for the start bit, shifts in a short or long reply and checks framing and CRC7
`timescale 1ns/100ps
`default_nettype none
`include "sdInit_macros.svh"

module sdRespReceiver (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   riseTick,
    input  wire                   cmdIn,
    input  wire                   recvStart,
    input  sdInitPkg::respKind_t  respKind,
    output logic                  recvDone,
    output logic                  recvOk,
    output logic [47:0]           respField
);

    logic [1:0]           cmdSync;
    logic                 sampleBit;
    logic                 armed;
    logic                 receiving;
    logic                 transBit;
    logic [7:0]           bitCnt;
    logic [7:0]           lastIdx;
    sdInitPkg::respKind_t kindReg;
    logic                 takeBit;
    logic                 crcEn;
    logic [6:0]           crc;
    logic                 crcOk;

    assign sampleBit = cmdSync[1];
    // A low bit while armed is the start bit and every later bit counts
    assign takeBit   = riseTick && armed && (receiving || !sampleBit);
    assign crcEn     = takeBit && (bitCnt < 8'(`SD_FRAME_BITS - 8));
    assign lastIdx   = (kindReg == sdInitPkg::long136) ? 8'(`SD_LONG_BITS - 1)
                                                       : 8'(`SD_FRAME_BITS - 1);
    // Received CRC sits at the bottom of the window just before the stop bit
    assign crcOk     = (kindReg != sdInitPkg::short48) || (respField[6:0] == crc);

    sdCrc7 crcCheck (
        .clk     (clk),
        .arstN   (arstN),
        .clear   (recvStart),
        .shiftEn (crcEn),
        .dataBit (sampleBit),
        .crc     (crc)
    );

    // Sliding window of the last 48 bits
    always_ff @(posedge clk) begin
        if (takeBit) begin
            respField <= {respField[46:0], sampleBit};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmdSync   <= 2'b11;
            armed     <= 1'b0;
            receiving <= 1'b0;
            transBit  <= 1'b0;
            bitCnt    <= '0;
            kindReg   <= sdInitPkg::none;
            recvDone  <= 1'b0;
            recvOk    <= 1'b0;
        end else begin
            cmdSync  <= {cmdSync[0], cmdIn};
            recvDone <= 1'b0;
            if (recvStart) begin
                armed     <= 1'b1;
                receiving <= 1'b0;
                bitCnt    <= '0;
                kindReg   <= respKind;
            end else if (takeBit) begin
                receiving <= 1'b1;
                bitCnt    <= bitCnt + 1'b1;
                if (bitCnt == 8'd1) begin
                    transBit <= sampleBit;
                end
                if (bitCnt == lastIdx) begin
                    // Stop bit sampled now
                    armed     <= 1'b0;
                    receiving <= 1'b0;
                    recvDone  <= 1'b1;
                    recvOk    <= !transBit && sampleBit && crcOk;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sdBusTimer.sv
// Card clock divider with edge strobes, and the N_CC / N_RC gap counter
`timescale 1ns/100ps
`default_nettype none
`include "sdInit_macros.svh"

module sdBusTimer (
    input  wire  clk,
    input  wire  arstN,
    input  wire  gapStart,
    output logic sdClk,
    output logic fallTick,
    output logic riseTick,
    output logic gapDone
);

    localparam int HalfW = $clog2(`SD_CLK_HALF);
    localparam int GapW  = $clog2(`SD_GAP_CYCLES + 1);

    logic [HalfW-1:0] halfCnt;
    logic [GapW-1:0]  gapCnt;

    // ========================================================================
    // Card clock
    // ========================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halfCnt  <= '0;
            sdClk    <= 1'b0;
            fallTick <= 1'b0;
            riseTick <= 1'b0;
        end else begin
            fallTick <= 1'b0;
            riseTick <= 1'b0;
            if (halfCnt == HalfW'(`SD_CLK_HALF - 1)) begin
                halfCnt  <= '0;
                sdClk    <= !sdClk;
                // Strobes line up with the new clock level
                riseTick <= !sdClk;
                fallTick <= sdClk;
            end else begin
                halfCnt <= halfCnt + 1'b1;
            end
        end
    end

    // ========================================================================
    // Inter-command gap
    // ========================================================================
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            gapCnt  <= '0;
            gapDone <= 1'b0;
        end else begin
            gapDone <= riseTick && !gapStart && (gapCnt == GapW'(1));
            if (gapStart) begin
                gapCnt <= GapW'(`SD_GAP_CYCLES);
            end else if (riseTick && gapCnt != '0) begin
                gapCnt <= gapCnt - 1'b1;
            end
        end
    end

    // A new gap never starts while one is still counting
    assert property (@(posedge clk) disable iff (!arstN) gapStart |-> gapCnt == '0);

endmodule

`default_nettype wire

//--- design/sdInitFsm.sv
// Initialization sequencer
// Issues CMD0 through ACMD6 in order, judges each reply, latches the RCA
`timescale 1ns/100ps
`default_nettype none
`include "sdInit_macros.svh"

module sdInitFsm (
    input  wire                   clk,
    input  wire                   arstN,
    input  wire                   sendDone,
    input  wire                   recvDone,
    input  wire                   recvOk,
    input  wire [47:0]            respField,
    input  wire                   gapDone,
    output logic                  sendStart,
    output sdInitPkg::sdCmd_t     cmdIndex,
    output logic [31:0]           cmdArg,
    output logic                  recvStart,
    output sdInitPkg::respKind_t  respKind,
    output logic                  gapStart,
    output logic                  done,
    output logic [15:0]           rca,
    output logic                  error
);

    sdInitPkg::seqState_t state;
    sdInitPkg::seqState_t retState;

    assign done  = (state == sdInitPkg::finished);
    assign error = (state == sdInitPkg::failed);

    // Load one command and hand it to the sender
    task automatic launch(input sdInitPkg::sdCmd_t idx, input logic [31:0] arg,
                          input sdInitPkg::respKind_t kind, input sdInitPkg::seqState_t nxt);
        cmdIndex  <= idx;
        cmdArg    <= arg;
        respKind  <= kind;
        retState  <= nxt;
        sendStart <= 1'b1;
        state     <= sdInitPkg::issue;
    endtask

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= sdInitPkg::idle;
            retState  <= sdInitPkg::idle;
            cmdIndex  <= sdInitPkg::goIdle;
            cmdArg    <= '0;
            respKind  <= sdInitPkg::none;
            sendStart <= 1'b0;
            recvStart <= 1'b0;
            gapStart  <= 1'b0;
            rca       <= '0;
        end else begin
            sendStart <= 1'b0;
            recvStart <= 1'b0;
            gapStart  <= 1'b0;
            case (state)
                // ============================================================
                // Command steps
                // ============================================================
                sdInitPkg::idle:    state <= sdInitPkg::go;
                sdInitPkg::go:      launch(sdInitPkg::goIdle, 32'd0, sdInitPkg::none,
                                           sdInitPkg::ifCond);
                sdInitPkg::ifCond:  launch(sdInitPkg::sendIfCond, `SD_IF_ARG,
                                           sdInitPkg::short48, sdInitPkg::ifCheck);
                // Card must echo the pattern we sent
                sdInitPkg::ifCheck: state <= (respField[15:8] == `SD_CHECK_PATTERN)
                                             ? sdInitPkg::appCmd : sdInitPkg::failed;
                sdInitPkg::appCmd:  launch(sdInitPkg::appCommand, 32'd0, sdInitPkg::short48,
                                           sdInitPkg::opCond);
                // R3 carries no valid CRC
                sdInitPkg::opCond:  launch(sdInitPkg::sendOpCond, `SD_OPCOND_ARG,
                                           sdInitPkg::shortNoCrc, sdInitPkg::opCheck);
                sdInitPkg::opCheck: begin
                    // Index and CRC fields of R3 read as all ones
                    if (respField[45:40] != 6'h3F || respField[7:1] != 7'h7F) begin
                        state <= sdInitPkg::failed;
                    end else if (!respField[39]) begin
                        // Still powering up so ask again
                        state <= sdInitPkg::appCmd;
                    end else begin
                        state <= sdInitPkg::allCid;
                    end
                end
                sdInitPkg::allCid:    launch(sdInitPkg::allSendCid, 32'd0, sdInitPkg::long136,
                                             sdInitPkg::relAddr);
                sdInitPkg::relAddr:   launch(sdInitPkg::sendRelAddr, 32'd0, sdInitPkg::short48,
                                             sdInitPkg::rcaLatch);
                sdInitPkg::rcaLatch: begin
                    rca   <= respField[39:24];
                    state <= sdInitPkg::select;
                end
                sdInitPkg::select:    launch(sdInitPkg::selectCard, {rca, 16'd0},
                                             sdInitPkg::short48, sdInitPkg::busAppCmd);
                sdInitPkg::busAppCmd: launch(sdInitPkg::appCommand, {rca, 16'd0},
                                             sdInitPkg::short48, sdInitPkg::busWidth);
                sdInitPkg::busWidth:  launch(sdInitPkg::setBusWidth, `SD_BUSWIDTH_ARG,
                                             sdInitPkg::short48, sdInitPkg::finished);

                // ============================================================
                // Shared bus phases
                // ============================================================
                sdInitPkg::issue: begin
                    if (sendDone) begin
                        if (respKind == sdInitPkg::none) begin
                            gapStart <= 1'b1;
                            state    <= sdInitPkg::gap;
                        end else begin
                            recvStart <= 1'b1;
                            state     <= sdInitPkg::await;
                        end
                    end
                end
                sdInitPkg::await: begin
                    if (recvDone) begin
                        gapStart <= recvOk;
                        state    <= recvOk ? sdInitPkg::gap : sdInitPkg::failed;
                    end
                end
                sdInitPkg::gap: begin
                    if (gapDone) begin
                        state <= retState;
                    end
                end
                // finished and failed hold until reset
                default: state <= state;
            endcase
        end
    end

    // Replies only come back while the sequencer waits for one
    assert property (@(posedge clk) disable iff (!arstN) recvDone |-> state == sdInitPkg::await);

endmodule

`default_nettype wire

//--- design/sdCardInit.sv
// Top level of the SD-card initialization host
// Card clock timer, command sender, response receiver and sequencer
`timescale 1ns/100ps
`default_nettype none

module sdCardInit (
    input  wire         clk,
    input  wire         arstN,
    output logic        sdClk,
    output logic        cmdOut,
    output logic        cmdOutEn,
    input  wire         cmdIn,
    output logic        done,
    output logic [15:0] rca,
    output logic        error
);

    logic                 fallTick;
    logic                 riseTick;
    logic                 gapStart;
    logic                 gapDone;
    logic                 sendStart;
    logic                 sendDone;
    sdInitPkg::sdCmd_t    cmdIndex;
    logic [31:0]          cmdArg;
    logic                 recvStart;
    sdInitPkg::respKind_t respKind;
    logic                 recvDone;
    logic                 recvOk;
    logic [47:0]          respField;

    sdBusTimer timer (
        .clk(clk), .arstN(arstN), .gapStart(gapStart), .sdClk(sdClk),
        .fallTick(fallTick), .riseTick(riseTick), .gapDone(gapDone)
    );

    sdCmdSender sender (
        .clk(clk), .arstN(arstN), .fallTick(fallTick), .sendStart(sendStart),
        .cmdIndex(cmdIndex), .cmdArg(cmdArg), .cmdOut(cmdOut),
        .cmdOutEn(cmdOutEn), .sendDone(sendDone)
    );

    sdRespReceiver receiver (
        .clk(clk), .arstN(arstN), .riseTick(riseTick), .cmdIn(cmdIn),
        .recvStart(recvStart), .respKind(respKind), .recvDone(recvDone),
        .recvOk(recvOk), .respField(respField)
    );

    sdInitFsm sequencer (
        .clk(clk), .arstN(arstN), .sendDone(sendDone), .recvDone(recvDone),
        .recvOk(recvOk), .respField(respField), .gapDone(gapDone),
        .sendStart(sendStart), .cmdIndex(cmdIndex), .cmdArg(cmdArg),
        .recvStart(recvStart), .respKind(respKind), .gapStart(gapStart),
        .done(done), .rca(rca), .error(error)
    );

endmodule

`default_nettype wire

//--- testbench/tbSdCardInit.sv
// Testbench for the SD-card initialization host
// Clock, reset, a card model, the reference frame builder and the frame checks
`timescale 1ns/100ps
`default_nettype none
`include "sdInit_macros.svh"

module tbSdCardInit;

    localparam int  TimeoutCycles = 2000;
    // Shortest legal spacing between the last bit of one transfer and the next start bit
    localparam time MinGapNs = 64'(2 * `SD_CLK_HALF * 100 * (`SD_GAP_CYCLES + 1));

    logic        clk;
    logic        arstN;
    logic        cmdIn;
    logic        sdClk;
    logic        cmdOut;
    logic        cmdOutEn;
    logic        done;
    logic [15:0] rca;
    logic        error;

    // Card state for the running session
    int          busyLeft;
    logic        patternBad;
    logic        crcBad;
    logic [15:0] rcaVal;
    time         busEnd;
    logic [47:0] expQ[$];
    logic [47:0] rxQ[$];

    sdCardInit UUT (
        .clk(clk), .arstN(arstN), .sdClk(sdClk), .cmdOut(cmdOut), .cmdOutEn(cmdOutEn),
        .cmdIn(cmdIn), .done(done), .rca(rca), .error(error)
    );

    always #50 clk = !clk;

    // ========================================================================
    // Failure reporting
    // ========================================================================
    task automatic stopOnFailure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic abortRun(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        stopOnFailure();
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
        $display("error at %0t ns: %s got %0h expected %0h", $time, name, got, want);
        stopOnFailure();
    endtask

    // ========================================================================
    // Reference frame of start 0, direction bit, index, argument, CRC7, end 1
    // ========================================================================
    function automatic logic [47:0] frameOf(input logic hostBit, input logic [5:0] idx,
                                            input logic [31:0] arg);
        logic [39:0] head;
        logic [6:0]  crc;
        logic        fb;
        int          i;
        head = {1'b0, hostBit, idx, arg};
        crc  = '0;
        // x^7 + x^3 + 1 taken MSB first
        for (i = 39; i >= 0; i--) begin
            fb  = head[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return {head, crc, 1'b1};
    endfunction

    // Compare every frame the card saw with the next expected one
    always @(posedge sdClk) begin : compareFrames
        logic [47:0] got;
        logic [47:0] want;
        while (rxQ.size() > 0) begin
            got = rxQ.pop_front();
            want = expQ.pop_front();
            assert (got == want) else reportMismatch("cmdOut frame", 64'(got), 64'(want));
        end
    end

    task automatic resetDut();
        @(posedge clk);
        #10;
        arstN  = 1'b0;
        cmdIn  = 1'b1;
        busEnd = 0;
        repeat (16) @(posedge clk);
        #10;
        assert (!sdClk) else reportMismatch("sdClk", 64'(sdClk), 64'd0);
        assert (!cmdOutEn) else reportMismatch("cmdOutEn", 64'(cmdOutEn), 64'd0);
        assert (!done) else reportMismatch("done", 64'(done), 64'd0);
        assert (!error) else reportMismatch("error", 64'(error), 64'd0);
        assert (rca == 16'd0) else reportMismatch("rca", 64'(rca), 64'd0);
        arstN = 1'b1;
    endtask

    // ========================================================================
    // Card model
    // ========================================================================
    task automatic collectFrame(output logic [47:0] frame);
        int waitCnt;
        int i;
        waitCnt = 0;
        frame   = '0;
        @(posedge sdClk);
        while (!cmdOutEn) begin
            waitCnt++;
            assert (waitCnt < TimeoutCycles) else abortRun("no command frame started in time");
            @(posedge sdClk);
        end
        // First bit must respect N_CC / N_RC
        if (busEnd > 0) begin
            assert ($time - busEnd >= MinGapNs)
            else abortRun("a command frame started before the inter-command gap ended");
        end
        for (i = 47; i >= 0; i--) begin
            assert (cmdOutEn) else abortRun("cmdOutEn dropped in the middle of a command frame");
            frame[i] = cmdOut;
            if (i > 0) begin
                @(posedge sdClk);
            end
        end
        busEnd = $time;
        rxQ.push_back(frame);
    endtask

    task automatic answer(input logic [47:0] cmd);
        logic [135:0] bits;
        logic [47:0]  r;
        int           len;
        int           delay;
        int           i;
        bits = '0;
        r    = '0;
        len  = `SD_FRAME_BITS;
        case (cmd[45:40])
            6'd8:  r = frameOf(1'b0, 6'd8,
                               {24'h000001, (patternBad ? 8'h55 : `SD_CHECK_PATTERN)});
            6'd55: r = frameOf(1'b0, 6'd55, 32'h00000120);
            6'd41: begin
                // R3 with OCR bit 31 low while still busy
                r = frameOf(1'b0, 6'h3F, (busyLeft > 0) ? 32'h00FF8000 : 32'hC0FF8000);
                r[7:1] = 7'h7F;
                if (busyLeft > 0) begin
                    busyLeft--;
                end
            end
            6'd2: begin
                // R2 carries a random CID that the DUT does not judge
                bits = {2'b00, 6'h3F, 32'($urandom), 32'($urandom), 32'($urandom),
                        24'($urandom), 7'h7F, 1'b1};
                len  = `SD_LONG_BITS;
            end
            6'd3:  r = frameOf(1'b0, 6'd3, {rcaVal, 16'h0500});
            6'd7:  r = frameOf(1'b0, 6'd7, 32'h00000700) ^ (crcBad ? 48'h2 : 48'h0);
            6'd6:  r = frameOf(1'b0, 6'd6, 32'h00000920);
            default: len = 0;
        endcase
        if (len == `SD_FRAME_BITS) begin
            bits[135 -: 48] = r;
        end
        if (len > 0) begin
            delay = 2 + $urandom % 9;
            repeat (delay) @(negedge sdClk);
            for (i = 0; i < len; i++) begin
                if (i > 0) begin
                    @(negedge sdClk);
                end
                #10;
                cmdIn = bits[135 - i];
            end
            // Stop bit is taken on this rising edge
            @(posedge sdClk);
            busEnd = $time;
        end
    endtask

    // Wait for done or error while the bus stays quiet
    task automatic waitForEnd();
        int n;
        n = 0;
        @(posedge sdClk);
        while (!done && !error) begin
            assert (!cmdOutEn) else abortRun("a command frame started after the last expected one");
            n++;
            assert (n < TimeoutCycles) else abortRun("neither done nor error rose in time");
            @(posedge sdClk);
        end
    endtask

    task automatic expectQuietBus(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge sdClk);
            assert (!cmdOutEn) else abortRun("a command frame started after the error");
            assert (error && !done) else abortRun("the error state did not hold");
        end
    endtask

    // ========================================================================
    // One session from reset to done or error
    // ========================================================================
    task automatic runSession(input int busyTimes, input logic badPattern, input logic badCrc);
        logic [47:0] cmd;
        int          frames;
        int          k;
        expQ.delete();
        rxQ.delete();
        busyLeft   = busyTimes;
        patternBad = badPattern;
        crcBad     = badCrc;
        rcaVal     = 16'($urandom % 32'hFFFF) + 16'd1;
        resetDut();
        expQ.push_back(frameOf(1'b1, 6'd0, 32'd0));
        expQ.push_back(frameOf(1'b1, 6'd8, `SD_IF_ARG));
        if (!badPattern) begin
            // One CMD55 and CMD41 pair per busy reply and one for the ready reply
            for (k = 0; k <= busyTimes; k++) begin
                expQ.push_back(frameOf(1'b1, 6'd55, 32'd0));
                expQ.push_back(frameOf(1'b1, 6'd41, `SD_OPCOND_ARG));
            end
            expQ.push_back(frameOf(1'b1, 6'd2, 32'd0));
            expQ.push_back(frameOf(1'b1, 6'd3, 32'd0));
            expQ.push_back(frameOf(1'b1, 6'd7, {rcaVal, 16'd0}));
            if (!badCrc) begin
                expQ.push_back(frameOf(1'b1, 6'd55, {rcaVal, 16'd0}));
                expQ.push_back(frameOf(1'b1, 6'd6, `SD_BUSWIDTH_ARG));
            end
        end
        frames = expQ.size();
        for (k = 0; k < frames; k++) begin
            collectFrame(cmd);
            answer(cmd);
        end
        waitForEnd();
        if (badPattern || badCrc) begin
            assert (error) else reportMismatch("error", 64'(error), 64'd1);
            assert (!done) else reportMismatch("done", 64'(done), 64'd0);
            expectQuietBus(4 * `SD_GAP_CYCLES);
        end else begin
            assert (done) else reportMismatch("done", 64'(done), 64'd1);
            assert (!error) else reportMismatch("error", 64'(error), 64'd0);
            assert (rca == rcaVal) else reportMismatch("rca", 64'(rca), 64'(rcaVal));
        end
    endtask

    initial begin
        int busyTimes;
        clk    = 1'b0;
        arstN  = 1'b0;
        cmdIn  = 1'b1;
        busEnd = 0;
        void'($urandom(68));
        busyTimes = 1 + $urandom % 4;
        runSession(busyTimes, 1'b0, 1'b0);
        // CMD7 reply with a broken CRC
        runSession(0, 1'b0, 1'b1);
        // Wrong CMD8 echo
        runSession(0, 1'b1, 1'b0);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sdCardInit.f
+incdir+design
design/sdInitPkg.sv
design/sdCrc7.sv
design/sdCmdSender.sv
design/sdRespReceiver.sv
design/sdBusTimer.sv
design/sdInitFsm.sv
design/sdCardInit.sv
testbench/tbSdCardInit.sv

//--- Makefile
# Verilator build and run of the SD-card initialization host testbench
TOP = tbSdCardInit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sdCardInit.f \
		--top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
